// File: Bender.yml
package:
  name: rv_core

export_include_dirs:
  - include

sources:
  - hw/rv_pkg.sv
  - hw/fetch_unit.sv
  - hw/decode_unit.sv
  - hw/execute_unit.sv
  - hw/regfile.sv
  - hw/rv_core_top.sv
  - target: test
    files:
      - test/tb_axi_mem.sv
      - test/tb_core.sv

// File: hw/decode_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// combinational; opcodes outside the ALU/branch/jump set give CLS_NONE
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "rv_consts.svh"

module decode_unit (
    input  logic [`RV_XLEN-1:0] inst,
    output rv_pkg::decoded_t    dec
);
    import rv_pkg::*;

    logic [6:0]          opcode;
    logic [6:0]          funct7;
    logic [2:0]          funct3;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_j;
    inst_class_t         cls;
    alu_op_t             alu_op;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // immediate formats
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        case (opcode)
            `RV_OP_OP:     cls = CLS_R;
            `RV_OP_OP_IMM: cls = CLS_I;
            `RV_OP_LUI,
            `RV_OP_AUIPC:  cls = CLS_U;
            `RV_OP_BRANCH: cls = CLS_B;
            `RV_OP_JAL:    cls = CLS_J;
            `RV_OP_JALR:   cls = CLS_JR;
            default:       cls = CLS_NONE;
        endcase
    end

    // ALU op only matters for R and I; everything else adds
    always_comb begin
        alu_op = ALU_ADD;
        if (cls == CLS_R || cls == CLS_I) begin
            case (funct3)
                `RV_F3_ADD: begin
                    // ADDI has no SUB form, imm bits would alias funct7
                    if (cls == CLS_R && funct7 == `RV_F7_ALT) alu_op = ALU_SUB;
                end
                `RV_F3_SLL:  alu_op = ALU_SLL;
                `RV_F3_SLT:  alu_op = ALU_SLT;
                `RV_F3_SLTU: alu_op = ALU_SLTU;
                `RV_F3_XOR:  alu_op = ALU_XOR;
                `RV_F3_SRL:  alu_op = funct7[5] ? ALU_SRA : ALU_SRL; // SRAI too
                `RV_F3_OR:   alu_op = ALU_OR;
                `RV_F3_AND:  alu_op = ALU_AND;
                default:     alu_op = ALU_ADD;
            endcase
        end
    end

    always_comb begin
        dec        = '0;
        dec.cls    = cls;
        dec.alu_op = alu_op;
        dec.funct3 = funct3;
        dec.rd     = inst[11:7];
        dec.rs1    = inst[19:15];
        dec.rs2    = inst[24:20];
        dec.lui    = (opcode == `RV_OP_LUI);
        case (cls)
            CLS_I, CLS_JR: dec.imm = imm_i;
            CLS_U:         dec.imm = imm_u;
            CLS_B:         dec.imm = imm_b;
            CLS_J:         dec.imm = imm_j;
            default:       dec.imm = '0;
        endcase
    end

endmodule

// File: hw/execute_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// combinational; retire_valid follows inst_valid with no stall
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "rv_consts.svh"

module execute_unit (
    input  logic                inst_valid,
    input  logic [`RV_XLEN-1:0] inst_pc,
    input  rv_pkg::decoded_t    dec,
    input  logic [`RV_XLEN-1:0] rs1_data,
    input  logic [`RV_XLEN-1:0] rs2_data,
    output logic                retire_valid,
    output rv_pkg::retire_t     retire
);
    import rv_pkg::*;

    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] alu_res;
    logic [`RV_XLEN-1:0] pc_plus4;
    logic [`RV_XLEN-1:0] next_pc;
    logic                taken;
    logic                link;

    assign pc_plus4 = inst_pc + 32'd4;

    // operand select
    always_comb begin
        case (dec.cls)
            CLS_R: begin
                op_a = rs1_data;
                op_b = rs2_data;
            end
            CLS_U: begin
                op_a = dec.lui ? '0 : inst_pc;
                op_b = dec.imm;
            end
            CLS_B, CLS_J: begin
                op_a = inst_pc;   // target = pc + offset
                op_b = dec.imm;
            end
            default: begin    // I, JR, NONE
                op_a = rs1_data;
                op_b = dec.imm;
            end
        endcase
    end

    // ALU
    always_comb begin
        case (dec.alu_op)
            ALU_ADD:  alu_res = op_a + op_b;
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_SLL:  alu_res = op_a << op_b[4:0];
            ALU_SLT:  alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_res = {31'b0, op_a < op_b};
            ALU_XOR:  alu_res = op_a ^ op_b;
            ALU_SRL:  alu_res = op_a >> op_b[4:0];
            ALU_SRA:  alu_res = $unsigned($signed(op_a) >>> op_b[4:0]);
            ALU_OR:   alu_res = op_a | op_b;
            ALU_AND:  alu_res = op_a & op_b;
            default:  alu_res = op_a + op_b;
        endcase
    end

    // branch compare on the register values, not the ALU operands
    always_comb begin
        case (dec.funct3)
            `RV_F3_BEQ:  taken = (rs1_data == rs2_data);
            `RV_F3_BNE:  taken = (rs1_data != rs2_data);
            `RV_F3_BLT:  taken = ($signed(rs1_data) < $signed(rs2_data));
            `RV_F3_BGE:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            `RV_F3_BLTU: taken = (rs1_data < rs2_data);
            `RV_F3_BGEU: taken = (rs1_data >= rs2_data);
            default:     taken = 1'b0;
        endcase
    end

    always_comb begin
        case (dec.cls)
            CLS_B:   next_pc = taken ? alu_res : pc_plus4;
            CLS_J:   next_pc = alu_res;
            CLS_JR:  next_pc = {alu_res[`RV_XLEN-1:1], 1'b0};
            default: next_pc = pc_plus4;
        endcase
    end

    assign link = (dec.cls == CLS_J) || (dec.cls == CLS_JR);

    assign retire_valid   = inst_valid;
    assign retire.pc      = inst_pc;
    assign retire.next_pc = next_pc;
    assign retire.rd      = dec.rd;
    assign retire.wdata   = link ? pc_plus4 : alu_res;
    assign retire.we      = (dec.rd != '0) && (dec.cls != CLS_B) && (dec.cls != CLS_NONE);

endmodule

// File: hw/fetch_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one read outstanding at most; rresp is not checked
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "rv_consts.svh"

module fetch_unit (
    input  logic                clk,
    input  logic                reset,
    // AXI4-Lite read address
    output logic                arvalid,
    input  logic                arready,
    output rv_pkg::axi_ar_t     ar,
    // AXI4-Lite read data
    input  logic                rvalid,
    output logic                rready,
    input  rv_pkg::axi_r_t      r,
    // to decode / execute
    output logic                inst_valid,
    output logic [`RV_XLEN-1:0] inst,
    output logic [`RV_XLEN-1:0] inst_pc,
    // from retire
    input  logic                retire_valid,
    input  logic [`RV_XLEN-1:0] next_pc
);
    import rv_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,  // only after reset
        ST_AR,    // address offered
        ST_R,     // waiting for data
        ST_EXEC   // instruction held for its retire cycle
    } fetch_state_t;

    fetch_state_t        state;
    fetch_state_t        state_nxt;
    logic [`RV_XLEN-1:0] pc;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: state_nxt = ST_AR;
            ST_AR:   if (arready) state_nxt = ST_R;
            ST_R:    if (rvalid) state_nxt = ST_EXEC;
            ST_EXEC: if (retire_valid) state_nxt = ST_AR;
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
            pc    <= `RV_RESET_PC;
        end else begin
            state <= state_nxt;
            if (retire_valid) pc <= next_pc; // closing edge of retire
        end
    end

    // instruction word, loaded on the R handshake
    always_ff @(posedge clk) begin
        if (state == ST_R && rvalid) begin
            inst <= r.rdata;
        end
    end

    // pc only moves in EXEC, so araddr is stable while arvalid waits
    assign arvalid   = (state == ST_AR);
    assign ar.araddr = pc;
    assign ar.arprot = 3'b000;   // unprivileged data
    assign rready    = (state == ST_R);

    assign inst_valid = (state == ST_EXEC);
    assign inst_pc    = pc;

endmodule

// File: hw/regfile.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// x0 reads as zero whatever is written to it
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "rv_consts.svh"

module regfile (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      we,
    input  logic [`RV_REG_ADDR_W-1:0] waddr,
    input  logic [`RV_XLEN-1:0]       wdata,
    input  logic [`RV_REG_ADDR_W-1:0] raddr1,
    input  logic [`RV_REG_ADDR_W-1:0] raddr2,
    output logic [`RV_XLEN-1:0]       rdata1,
    output logic [`RV_XLEN-1:0]       rdata2
);

    logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;  // end of retire cycle
        end
    end

    // read ports are asynchronous, execute sees them in the same cycle
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: hw/rv_core_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I core, AXI4-Lite read port only; retire cannot be stalled
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_core_top (
    input  logic            clk,
    input  logic            reset,
    output logic            arvalid,
    input  logic            arready,
    output rv_pkg::axi_ar_t ar,
    input  logic            rvalid,
    output logic            rready,
    input  rv_pkg::axi_r_t  r,
    output logic            retire_valid,
    output rv_pkg::retire_t retire
);
    import rv_pkg::*;

    logic                inst_valid;
    logic [`RV_XLEN-1:0] inst;
    logic [`RV_XLEN-1:0] inst_pc;
    decoded_t            dec;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;

    fetch_unit u_fetch (
        .clk          (clk),
        .reset        (reset),
        .arvalid      (arvalid),
        .arready      (arready),
        .ar           (ar),
        .rvalid       (rvalid),
        .rready       (rready),
        .r            (r),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .inst_pc      (inst_pc),
        .retire_valid (retire_valid),
        .next_pc      (retire.next_pc)
    );

    decode_unit u_decode (
        .inst (inst),
        .dec  (dec)
    );

    regfile u_regfile (
        .clk    (clk),
        .reset  (reset),
        .we     (retire_valid & retire.we),
        .waddr  (retire.rd),
        .wdata  (retire.wdata),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    execute_unit u_execute (
        .inst_valid   (inst_valid),
        .inst_pc      (inst_pc),
        .dec          (dec),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule

// File: hw/rv_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// types shared by the core; no load/store or CSR fields
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "rv_consts.svh"

package rv_pkg;

    // instruction class, drives operand select in execute
    typedef enum logic [2:0] {
        CLS_R,    // register-register ALU
        CLS_I,    // register-immediate ALU
        CLS_U,    // LUI / AUIPC
        CLS_B,    // conditional branch
        CLS_J,    // JAL
        CLS_JR,   // JALR
        CLS_NONE  // unsupported, retires as nop
    } inst_class_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_t;

    typedef struct packed {
        inst_class_t               cls;
        alu_op_t                   alu_op;
        logic [2:0]                funct3;  // branch condition
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [`RV_REG_ADDR_W-1:0] rs1;
        logic [`RV_REG_ADDR_W-1:0] rs2;
        logic [`RV_XLEN-1:0]       imm;
        logic                      lui;     // U class with zero base
    } decoded_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]       pc;
        logic [`RV_XLEN-1:0]       next_pc;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [`RV_XLEN-1:0]       wdata;
        logic                      we;
    } retire_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] araddr;
        logic [2:0]          arprot;
    } axi_ar_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] rdata;
        logic [1:0]          rresp;
    } axi_r_t;

endpackage

// File: include/rv_consts.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I constants, integer ALU, branch and jump subset only
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define RV_XLEN        32
`define RV_REG_ADDR_W  5
`define RV_NUM_REGS    32
`define RV_RESET_PC    32'h0000_0000

// major opcodes, inst[6:0]
`define RV_OP_OP       7'b0110011
`define RV_OP_OP_IMM   7'b0010011
`define RV_OP_LUI      7'b0110111
`define RV_OP_AUIPC    7'b0010111
`define RV_OP_BRANCH   7'b1100011
`define RV_OP_JAL      7'b1101111
`define RV_OP_JALR     7'b1100111

`define RV_F3_ADD      3'b000 // also SUB
`define RV_F3_SLL      3'b001
`define RV_F3_SLT      3'b010
`define RV_F3_SLTU     3'b011
`define RV_F3_XOR      3'b100
`define RV_F3_SRL      3'b101 // also SRA
`define RV_F3_OR       3'b110
`define RV_F3_AND      3'b111
`define RV_F3_BEQ      3'b000
`define RV_F3_BNE      3'b001
`define RV_F3_BLT      3'b100
`define RV_F3_BGE      3'b101
`define RV_F3_BLTU     3'b110
`define RV_F3_BGEU     3'b111

`define RV_F7_ALT      7'b0100000 // SUB / SRA

`endif

// File: src.f
+incdir+include
hw/rv_pkg.sv
hw/fetch_unit.sv
hw/decode_unit.sv
hw/execute_unit.sv
hw/regfile.sv
hw/rv_core_top.sv
test/tb_axi_mem.sv
test/tb_core.sv

// File: test/tb_axi_mem.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// read-only AXI4-Lite memory, one read in flight, 0 to 3 cycle delays
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_axi_mem #(
    parameter int          MEM_WORDS = 256,
    parameter logic [31:0] SEED      = 32'h1
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            arvalid,
    output logic            arready,
    input  rv_pkg::axi_ar_t ar,
    output logic            rvalid,
    input  logic            rready,
    output rv_pkg::axi_r_t  r
);
    import rv_pkg::*;

    logic [31:0] mem [MEM_WORDS];  // written by the testbench before reset ends
    logic [31:0] rng;
    logic [31:0] addr_q;
    logic        rst_q;
    logic        ar_fire;
    logic        r_fire;
    logic        r_busy;
    int          ar_cnt;
    int          r_cnt;

    // xorshift32, two low bits give the delay
    function int next_delay();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return int'(rng[1:0]);
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        if (addr[31:2] < MEM_WORDS) begin
            return mem[addr[31:2]];
        end
        return ~addr;  // outside the array
    endfunction

    initial begin
        arready = 1'b0;
        rvalid  = 1'b0;
        r       = '0;
        rng     = SEED;
        r_busy  = 1'b0;
        ar_cnt  = 0;
        r_cnt   = 0;
    end

    // handshakes seen on the rising edge, acted on at the falling edge
    always @(posedge clk) begin
        rst_q   <= reset;
        ar_fire <= arvalid && arready;
        r_fire  <= rvalid && rready;
        if (arvalid && arready) addr_q <= ar.araddr;
    end

    always @(negedge clk) begin
        if (rst_q) begin
            arready = 1'b0;
            rvalid  = 1'b0;
            r_busy  = 1'b0;
            ar_cnt  = next_delay();
        end else begin
            if (ar_fire) begin
                arready = 1'b0;
                r_busy  = 1'b1;
                r_cnt   = next_delay();
            end
            if (r_fire) begin
                rvalid = 1'b0;
                r_busy = 1'b0;
                ar_cnt = next_delay();
            end
            if (arvalid && !arready && !r_busy) begin
                if (ar_cnt == 0) arready = 1'b1;
                else ar_cnt--;
            end
            if (r_busy && !rvalid) begin
                if (r_cnt == 0) begin
                    rvalid  = 1'b1;
                    r.rdata = read_word(addr_q);
                    r.rresp = 2'b00;  // OKAY
                end else begin
                    r_cnt--;
                end
            end
        end
    end

endmodule

// File: test/tb_core.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// random ALU program, then fixed branch/jump block ending in a self-jump
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "rv_consts.svh"

module tb_core;
    import rv_pkg::*;

    localparam int          MEM_WORDS  = 256;
    localparam int          RAND_INSTS = 200;
    localparam logic [31:0] SEED       = 32'h39560b45;

    logic      clk;
    logic      reset;
    logic      arvalid;
    logic      arready;
    axi_ar_t   ar;
    logic      rvalid;
    logic      rready;
    axi_r_t    r;
    logic      retire_valid;
    retire_t   retire;

    logic [31:0] prog [MEM_WORDS];
    logic [31:0] model_regs [32];
    logic [31:0] model_pc;
    logic [31:0] rng;
    axi_ar_t     ar_held;
    logic        ar_wait_d;
    logic        r_fire_d;
    logic        done;
    logic        timed_out;
    int          prog_len;
    int          timeout_cycles;
    int          cycle_cnt;
    int          reset_cycles;
    int          retired;
    int          errors;

    tb_axi_mem #(.MEM_WORDS(MEM_WORDS), .SEED(SEED)) u_mem (
        .clk     (clk),
        .reset   (reset),
        .arvalid (arvalid),
        .arready (arready),
        .ar      (ar),
        .rvalid  (rvalid),
        .rready  (rready),
        .r       (r)
    );

    rv_core_top u_dut (
        .clk          (clk),
        .reset        (reset),
        .arvalid      (arvalid),
        .arready      (arready),
        .ar           (ar),
        .rvalid       (rvalid),
        .rready       (rready),
        .r            (r),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    always #20 clk = ~clk;

    function logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // instruction encoders
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `RV_OP_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `RV_OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, `RV_OP_JAL};
    endfunction

    task automatic emit(input logic [31:0] word);
        prog[prog_len] = word;
        prog_len++;
    endtask

    task automatic build_program();
        logic [31:0] rnd;
        logic [31:0] sel;
        logic [11:0] imm;
        logic [6:0]  f7;
        logic [4:0]  ra;
        logic [4:0]  rb;
        int          label;
        int          hi;
        for (int i = 0; i < MEM_WORDS; i++) begin
            prog[i] = ~(i * 4);  // fill, never fetched in a good run
        end
        prog_len = 0;
        for (int n = 0; n < RAND_INSTS; n++) begin
            rnd = next_rand();
            sel = next_rand();  // rd, rs1, rs2, alt bit
            imm = rnd[31:20];
            f7  = 7'd0;
            if ((rnd[10:8] == `RV_F3_ADD || rnd[10:8] == `RV_F3_SRL) && sel[15]) f7 = `RV_F7_ALT;
            case (rnd[2:0])
                3'd0, 3'd1, 3'd2: emit(enc_r(f7, sel[14:10], sel[9:5], rnd[10:8], sel[4:0]));
                3'd3, 3'd4, 3'd5: begin
                    if (rnd[10:8] == `RV_F3_SLL) imm = {7'd0, imm[4:0]};
                    if (rnd[10:8] == `RV_F3_SRL) imm = {1'b0, sel[15], 5'd0, imm[4:0]};
                    emit(enc_i(imm, sel[9:5], rnd[10:8], sel[4:0], `RV_OP_OP_IMM));
                end
                3'd6:    emit(enc_u(rnd[31:12], sel[4:0], `RV_OP_LUI));
                default: emit(enc_u(rnd[31:12], sel[4:0], `RV_OP_AUIPC));
            endcase
        end
        // x1 = 5, x2 = -3, x3 = 5
        emit(enc_i(12'd5, 5'd0, `RV_F3_ADD, 5'd1, `RV_OP_OP_IMM));
        emit(enc_i(-12'sd3, 5'd0, `RV_F3_ADD, 5'd2, `RV_OP_OP_IMM));
        emit(enc_i(12'd5, 5'd0, `RV_F3_ADD, 5'd3, `RV_OP_OP_IMM));
        // pairs (x1,x3) (x1,x2) (x2,x1) hit taken and not taken for every funct3
        for (int b = 0; b < 8; b++) begin
            if (b != 2 && b != 3) begin
                for (int p = 0; p < 3; p++) begin
                    ra = (p == 2) ? 5'd2 : 5'd1;
                    rb = (p == 0) ? 5'd3 : ((p == 1) ? 5'd2 : 5'd1);
                    emit(enc_b(13'd8, rb, ra, 3'(b)));
                    emit(enc_i(12'd1, 5'd7, `RV_F3_ADD, 5'd7, `RV_OP_OP_IMM));  // marker
                end
            end
        end
        emit(enc_j(21'd8, 5'd8));
        emit(enc_i(12'd1, 5'd7, `RV_F3_ADD, 5'd7, `RV_OP_OP_IMM));
        label = (prog_len + 4) * 4;  // the self-jump
        hi    = (label + 'h800) >> 12;
        emit(enc_u(20'(hi), 5'd9, `RV_OP_LUI));
        emit(enc_i(12'(label - (hi << 12)), 5'd9, `RV_F3_ADD, 5'd9, `RV_OP_OP_IMM));
        emit(enc_i(12'd1, 5'd9, 3'd0, 5'd10, `RV_OP_JALR));  // odd target, bit 0 dropped
        emit(enc_i(12'd1, 5'd7, `RV_F3_ADD, 5'd7, `RV_OP_OP_IMM));
        emit(enc_j(21'd0, 5'd0));
        for (int i = 0; i < MEM_WORDS; i++) begin
            u_mem.mem[i] = prog[i];
        end
    endtask

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            `RV_F3_ADD:  return alt ? a - b : a + b;
            `RV_F3_SLL:  return a << b[4:0];
            `RV_F3_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            `RV_F3_SLTU: return (a < b) ? 32'd1 : 32'd0;
            `RV_F3_XOR:  return a ^ b;
            `RV_F3_SRL:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            `RV_F3_OR:   return a | b;
            default:     return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            `RV_F3_BEQ:  return a == b;
            `RV_F3_BNE:  return a != b;
            `RV_F3_BLT:  return $signed(a) < $signed(b);
            `RV_F3_BGE:  return $signed(a) >= $signed(b);
            `RV_F3_BLTU: return a < b;
            `RV_F3_BGEU: return a >= b;
            default:     return 1'b0;
        endcase
    endfunction

    // expected retire for the instruction at pc, model registers updated
    function automatic retire_t predict_retire(input logic [31:0] pc);
        retire_t     exp;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        ins   = (pc[31:2] < MEM_WORDS) ? prog[pc[31:2]] : ~pc;
        a     = model_regs[ins[19:15]];
        b     = model_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        exp         = '0;
        exp.pc      = pc;
        exp.next_pc = pc + 4;
        exp.rd      = ins[11:7];
        exp.we      = 1'b1;
        case (ins[6:0])
            `RV_OP_OP:     exp.wdata = alu_ref(ins[14:12], ins[30], a, b);
            `RV_OP_OP_IMM: exp.wdata = alu_ref(ins[14:12],
                                               ins[14:12] == `RV_F3_SRL && ins[30], a, imm_i);
            `RV_OP_LUI:    exp.wdata = {ins[31:12], 12'd0};
            `RV_OP_AUIPC:  exp.wdata = {ins[31:12], 12'd0} + pc;
            `RV_OP_BRANCH: begin
                exp.we = 1'b0;
                if (branch_taken(ins[14:12], a, b)) exp.next_pc = pc + imm_b;
            end
            `RV_OP_JAL: begin
                exp.wdata   = pc + 4;
                exp.next_pc = pc + imm_j;
            end
            `RV_OP_JALR: begin
                exp.wdata   = pc + 4;
                exp.next_pc = (a + imm_i) & ~32'd1;
            end
            default: exp.we = 1'b0;  // unsupported, nop
        endcase
        if (exp.rd == 5'd0) exp.we = 1'b0;
        if (exp.we) model_regs[exp.rd] = exp.wdata;
        return exp;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_retire();
        retire_t exp;
        exp = predict_retire(model_pc);
        check_value("retire.pc", retire.pc, exp.pc);
        check_value("retire.next_pc", retire.next_pc, exp.next_pc);
        check_value("retire.we", retire.we, exp.we);
        if (exp.we) begin
            check_value("retire.rd", retire.rd, exp.rd);
            check_value("retire.wdata", retire.wdata, exp.wdata);
        end
        model_pc = exp.next_pc;
        retired++;
        if (exp.next_pc == exp.pc) done = 1'b1;  // final self-jump
    endtask

    // compare process, samples on the rising edge
    always @(posedge clk) begin
        if (reset) begin
            if (reset_cycles > 0) begin
                assert (arvalid === 1'b0 && rready === 1'b0 && retire_valid === 1'b0) else begin
                    $display("error at %0t: arvalid, rready or retire_valid high in reset", $time);
                    errors++;
                end
            end
            reset_cycles++;
        end else if (!done) begin
            assert (retire_valid === r_fire_d) else begin
                $display("error at %0t: retire_valid is not one cycle after the R handshake",
                         $time);
                errors++;
            end
            if (retire_valid === 1'b1) check_retire();
            if (ar_wait_d) begin
                assert (arvalid === 1'b1) else begin
                    $display("error at %0t: arvalid dropped before arready", $time);
                    errors++;
                end
                check_value("ar.araddr", ar.araddr, ar_held.araddr);
            end
            if (arvalid && arready) begin
                check_value("ar.araddr", ar.araddr, model_pc);
                check_value("ar.arprot", ar.arprot, 32'd0);
            end
            ar_wait_d = arvalid && !arready;
            ar_held   = ar;
            r_fire_d  = rvalid && rready;
        end
    end

    always @(posedge clk) begin
        if (!reset) begin
            cycle_cnt++;
            if (cycle_cnt >= timeout_cycles) timed_out = 1'b1;
        end
    end

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        rng          = SEED;
        model_pc     = `RV_RESET_PC;
        ar_held      = '0;
        ar_wait_d    = 1'b0;
        r_fire_d     = 1'b0;
        done         = 1'b0;
        timed_out    = 1'b0;
        cycle_cnt    = 0;
        reset_cycles = 0;
        retired      = 0;
        errors       = 0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        build_program();
        timeout_cycles = (prog_len + 20) * 12;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        wait (done || timed_out);
        if (!done) begin
            $display("run timed out after %0d cycles without reaching the self-jump",
                     cycle_cnt);
            errors++;
        end
        $display("%0d instructions retired, %0d errors", retired, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
